/* logic/vec_config.svh */
// Global size macros for the vector unit: vector length, beat width, register count, bus width
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// Bits in one vector register
`define VEC_VLEN 128

// One register file port beat, also one external memory word
`define VEC_DATA_WIDTH 64

// Architectural vector registers
`define VEC_NUM_REGS 32

// Wishbone word address width, in 64-bit words
`define VEC_ADDR_WIDTH 32

`endif

/* logic/vec_pkg.sv */
// Vector unit package: width typedefs, opcodes, command and Wishbone structs, FSM state enums
`include "vec_config.svh"

package vec_pkg;

    localparam int NUM_REGS       = `VEC_NUM_REGS;
    localparam int BEATS          = `VEC_VLEN / `VEC_DATA_WIDTH;   // Beats per vector
    localparam int BEAT_IDX_W     = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int BEAT_BYTES     = `VEC_DATA_WIDTH / 8;
    localparam int ELEM_WIDTH     = 32;
    localparam int ELEMS_PER_BEAT = `VEC_DATA_WIDTH / ELEM_WIDTH;

    typedef logic [`VEC_DATA_WIDTH-1:0]   beat_t;
    typedef logic [BEAT_BYTES-1:0]        byte_en_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  vreg_idx_t;
    typedef logic [BEAT_IDX_W-1:0]        beat_idx_t;
    typedef logic [`VEC_ADDR_WIDTH-1:0]   word_addr_t;
    typedef logic [ELEM_WIDTH-1:0]        elem_t;

    typedef enum logic [2:0] {
        VADD   = 3'd0,
        VSUB   = 3'd1,
        VAND   = 3'd2,
        VXOR   = 3'd3,
        VLOAD  = 3'd4,
        VSTORE = 3'd5
    } vec_op_e;

    // Sits in bits [25:0] of the command data word, mask in the low byte
    typedef struct packed {
        vec_op_e   op;
        vreg_idx_t vd;    // Destination, also the source of a store
        vreg_idx_t vs1;
        vreg_idx_t vs2;
        byte_en_t  mask;
    } vec_cmd_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_addr_t adr;
        beat_t      dat;
        byte_en_t   sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        beat_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic      valid;
        vreg_idx_t vreg;
    } vreg_rd_req_t;

    typedef struct packed {
        logic      valid;
        vreg_idx_t vreg;
        byte_en_t  be;
    } vreg_wr_req_t;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_ISSUE, SEQ_READ, SEQ_WRITE, SEQ_MEM, SEQ_ACK
    } seq_state_e;

    typedef enum logic [2:0] {
        LSU_IDLE, LSU_LD_BUS, LSU_LD_WR, LSU_ST_REQ, LSU_ST_WAIT, LSU_ST_CAP, LSU_ST_BUS
    } lsu_state_e;

endpackage

/* logic/vec_regfile.sv */
// Multi-beat vector register file with two ALU read ports, an ALU write port and load/store ports
`timescale 1ns/1ps

module vec_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  vec_pkg::vreg_rd_req_t rd_req_1,
    input  vec_pkg::vreg_rd_req_t rd_req_2,
    output vec_pkg::beat_t        rd_data_1,
    output vec_pkg::beat_t        rd_data_2,
    input  vec_pkg::vreg_wr_req_t wr_req,
    input  vec_pkg::beat_t        wr_data,
    input  vec_pkg::vreg_wr_req_t ld_req,
    input  vec_pkg::beat_t        ld_data,
    input  vec_pkg::vreg_rd_req_t st_req,
    output vec_pkg::beat_t        st_data
);
    import vec_pkg::*;

    localparam int NUM_RD = 3;    // rd_1, rd_2, st
    localparam int NUM_WR = 2;    // wr, ld
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS - 1);

    beat_t vec_data [NUM_REGS][BEATS];

    // Read-type ports, all share one streaming scheme
    vreg_rd_req_t rd_in   [NUM_RD];
    beat_t        rd_out  [NUM_RD];
    logic         rd_busy [NUM_RD];
    vreg_idx_t    rd_reg  [NUM_RD];
    beat_idx_t    rd_idx  [NUM_RD];

    // Write-type ports
    vreg_wr_req_t wr_in    [NUM_WR];
    beat_t        wr_din   [NUM_WR];
    logic         wr_busy  [NUM_WR];
    vreg_idx_t    wr_reg_q [NUM_WR];
    byte_en_t     wr_be_q  [NUM_WR];
    beat_idx_t    wr_idx   [NUM_WR];
    logic         wr_act   [NUM_WR];
    vreg_idx_t    wr_reg   [NUM_WR];
    byte_en_t     wr_be    [NUM_WR];
    beat_idx_t    wr_beat  [NUM_WR];

    assign rd_in[0]  = rd_req_1;
    assign rd_in[1]  = rd_req_2;
    assign rd_in[2]  = st_req;
    assign rd_data_1 = rd_out[0];
    assign rd_data_2 = rd_out[1];
    assign st_data   = rd_out[2];

    assign wr_in[0]  = wr_req;
    assign wr_in[1]  = ld_req;
    assign wr_din[0] = wr_data;
    assign wr_din[1] = ld_data;

    // Power-up contents: every byte of register c holds c
    initial begin
        for (int c = 0; c < NUM_REGS; c++) begin
            for (int k = 0; k < BEATS; k++) begin
                vec_data[c][k] = {BEAT_BYTES{8'(c)}};
            end
        end
    end

    // Reads: latch the register at the request edge, then one registered beat per cycle
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_RD; p++) begin
            if (rst) begin
                rd_busy[p] <= 1'b0;
                rd_idx[p]  <= '0;
            end else if (!rd_busy[p]) begin
                if (rd_in[p].valid) begin
                    rd_busy[p] <= 1'b1;
                    rd_reg[p]  <= rd_in[p].vreg;
                    rd_idx[p]  <= '0;
                end
            end else begin
                rd_out[p] <= vec_data[rd_reg[p]][rd_idx[p]];
                if (rd_idx[p] == LAST_BEAT) begin
                    rd_busy[p] <= 1'b0;
                end else begin
                    rd_idx[p] <= rd_idx[p] + 1'b1;
                end
            end
        end
    end

    // Beat 0 is written at the request edge straight from the request fields
    always_comb begin
        for (int p = 0; p < NUM_WR; p++) begin
            wr_act[p]  = wr_busy[p] || wr_in[p].valid;
            wr_reg[p]  = wr_busy[p] ? wr_reg_q[p] : wr_in[p].vreg;
            wr_be[p]   = wr_busy[p] ? wr_be_q[p] : wr_in[p].be;
            wr_beat[p] = wr_busy[p] ? wr_idx[p] : '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_WR; p++) begin
            if (rst) begin
                wr_busy[p] <= 1'b0;
                wr_idx[p]  <= '0;
            end else if (!wr_busy[p]) begin
                if (wr_in[p].valid && BEATS > 1) begin
                    wr_busy[p]  <= 1'b1;
                    wr_reg_q[p] <= wr_in[p].vreg;
                    wr_be_q[p]  <= wr_in[p].be;    // Same mask on every beat
                    wr_idx[p]   <= beat_idx_t'(1);
                end
            end else if (wr_idx[p] == LAST_BEAT) begin
                wr_busy[p] <= 1'b0;
            end else begin
                wr_idx[p] <= wr_idx[p] + 1'b1;
            end
        end
    end

    // Only one command runs at a time, so the two write ports never collide
    always @(posedge clk) begin
        for (int p = 0; p < NUM_WR; p++) begin
            for (int b = 0; b < BEAT_BYTES; b++) begin
                if (!rst && wr_act[p] && wr_be[p][b]) begin
                    vec_data[wr_reg[p]][wr_beat[p]][8*b +: 8] <= wr_din[p][8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/vec_alu.sv */
// Registered element-wise 32-bit vector ALU: add, subtract, AND, XOR on each incoming beat
`timescale 1ns/1ps

module vec_alu (
    input  logic             clk,
    input  logic             rst,
    input  vec_pkg::vec_op_e op,
    input  logic             in_valid,
    input  vec_pkg::beat_t   src_a,
    input  vec_pkg::beat_t   src_b,
    output logic             out_valid,
    output vec_pkg::beat_t   result
);
    import vec_pkg::*;

    beat_t res_next;

    // Element results wrap modulo 2^32 through the elem_t width
    function automatic elem_t elem_op(vec_op_e f, elem_t a, elem_t b);
        case (f)
            VADD:    return a + b;
            VSUB:    return a - b;
            VAND:    return a & b;
            VXOR:    return a ^ b;
            default: return '0;    // Memory ops never reach the ALU
        endcase
    endfunction

    always_comb begin
        res_next = '0;
        for (int e = 0; e < ELEMS_PER_BEAT; e++) begin
            res_next[e*ELEM_WIDTH +: ELEM_WIDTH] =
                elem_op(op, src_a[e*ELEM_WIDTH +: ELEM_WIDTH], src_b[e*ELEM_WIDTH +: ELEM_WIDTH]);
        end
    end

    // One stage, a new beat may enter every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result <= res_next;
        end
    end

endmodule

/* logic/vec_lsu.sv */
// Load/store unit: buffers one vector and moves it beat by beat over a Wishbone classic master
`timescale 1ns/1ps

module vec_lsu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  is_store,
    input  vec_pkg::word_addr_t   base_addr,
    input  vec_pkg::vreg_idx_t    vreg,
    input  vec_pkg::byte_en_t     mask,
    output logic                  done,
    output vec_pkg::vreg_wr_req_t ld_req,
    output vec_pkg::beat_t        ld_data,
    output vec_pkg::vreg_rd_req_t st_req,
    input  vec_pkg::beat_t        st_data,
    output vec_pkg::wb_req_t      mem_req,
    input  vec_pkg::wb_rsp_t      mem_rsp
);
    import vec_pkg::*;

    lsu_state_e state;
    beat_idx_t  idx;
    logic       last_beat;
    word_addr_t base_q;
    vreg_idx_t  vreg_q;
    byte_en_t   mask_q;
    beat_t      vec_buf [BEATS];

    assign last_beat = (idx == beat_idx_t'(BEATS - 1));

    // Bus outputs held steady until ack, address steps one word per beat
    always_comb begin
        mem_req.cyc = (state == LSU_LD_BUS) || (state == LSU_ST_BUS);
        mem_req.stb = mem_req.cyc;
        mem_req.we  = (state == LSU_ST_BUS);
        mem_req.adr = base_q + word_addr_t'(idx);
        mem_req.dat = vec_buf[idx];
        mem_req.sel = '1;
    end

    always_comb begin
        ld_req.valid = (state == LSU_LD_WR) && (idx == '0);    // One request streams all beats
        ld_req.vreg  = vreg_q;
        ld_req.be    = mask_q;
        ld_data      = vec_buf[idx];
        st_req.valid = (state == LSU_ST_REQ);
        st_req.vreg  = vreg_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LSU_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (start) begin
                        state <= is_store ? LSU_ST_REQ : LSU_LD_BUS;
                        idx   <= '0;
                    end
                end
                LSU_LD_BUS: begin
                    if (mem_rsp.ack) begin
                        idx   <= last_beat ? '0 : idx + 1'b1;
                        state <= last_beat ? LSU_LD_WR : LSU_LD_BUS;
                    end
                end
                LSU_LD_WR: begin
                    idx   <= last_beat ? '0 : idx + 1'b1;
                    state <= last_beat ? LSU_IDLE : LSU_LD_WR;
                    done  <= last_beat;
                end
                LSU_ST_REQ:  state <= LSU_ST_WAIT;
                LSU_ST_WAIT: state <= LSU_ST_CAP;    // Register file fetching beat 0
                LSU_ST_CAP: begin
                    idx   <= last_beat ? '0 : idx + 1'b1;
                    state <= last_beat ? LSU_ST_BUS : LSU_ST_CAP;
                end
                LSU_ST_BUS: begin
                    if (mem_rsp.ack) begin
                        idx   <= last_beat ? '0 : idx + 1'b1;
                        state <= last_beat ? LSU_IDLE : LSU_ST_BUS;
                        done  <= last_beat;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state == LSU_IDLE && start) begin
            base_q <= base_addr;
            vreg_q <= vreg;
            mask_q <= mask;
        end
        if (state == LSU_LD_BUS && mem_rsp.ack) begin
            vec_buf[idx] <= mem_rsp.dat;
        end
        if (state == LSU_ST_CAP) begin
            vec_buf[idx] <= st_data;
        end
    end

endmodule

/* logic/vec_sequencer.sv */
// Command sequencer: Wishbone classic command slave and control FSM driving register file, ALU and LSU
`timescale 1ns/1ps

module vec_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  vec_pkg::wb_req_t      cmd_req,
    output vec_pkg::wb_rsp_t      cmd_rsp,
    output vec_pkg::vreg_rd_req_t rd_req_1,
    output vec_pkg::vreg_rd_req_t rd_req_2,
    output vec_pkg::vec_op_e      alu_op,
    output logic                  alu_valid,
    input  logic                  alu_out_valid,
    output vec_pkg::vreg_wr_req_t wr_req,
    output logic                  lsu_start,
    output logic                  lsu_is_store,
    output vec_pkg::word_addr_t   lsu_addr,
    output vec_pkg::vreg_idx_t    lsu_vreg,
    output vec_pkg::byte_en_t     lsu_mask,
    input  logic                  lsu_done
);
    import vec_pkg::*;

    seq_state_e state;
    vec_cmd_t   cmd_q;
    word_addr_t addr_q;
    beat_idx_t  cnt;      // Read beats, then result beats
    logic       is_mem;
    logic       last_cnt;
    logic       cmd_sel;

    assign is_mem   = (cmd_q.op == VLOAD) || (cmd_q.op == VSTORE);
    assign last_cnt = (cnt == beat_idx_t'(BEATS - 1));
    assign cmd_sel  = cmd_req.cyc && cmd_req.stb;

    always_comb begin
        cmd_rsp.ack    = (state == SEQ_ACK);
        cmd_rsp.dat    = '0;    // Command port reads return zero
        rd_req_1.valid = (state == SEQ_ISSUE) && !is_mem;
        rd_req_1.vreg  = cmd_q.vs1;
        rd_req_2.valid = rd_req_1.valid;
        rd_req_2.vreg  = cmd_q.vs2;
        alu_op         = cmd_q.op;
        wr_req.valid   = (state == SEQ_WRITE) && alu_out_valid && (cnt == '0);
        wr_req.vreg    = cmd_q.vd;
        wr_req.be      = cmd_q.mask;
        lsu_start      = (state == SEQ_ISSUE) && is_mem;
        lsu_is_store   = (cmd_q.op == VSTORE);
        lsu_addr       = addr_q;
        lsu_vreg       = cmd_q.vd;    // Load target or store source
        lsu_mask       = cmd_q.mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            cnt       <= '0;
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= (state == SEQ_READ);    // Lines up with the registered read data
            case (state)
                SEQ_IDLE: begin
                    if (cmd_sel) begin
                        state <= cmd_req.we ? SEQ_ISSUE : SEQ_ACK;
                        cnt   <= '0;
                    end
                end
                SEQ_ISSUE: state <= is_mem ? SEQ_MEM : SEQ_READ;
                SEQ_READ: begin
                    cnt   <= last_cnt ? '0 : cnt + 1'b1;
                    state <= last_cnt ? SEQ_WRITE : SEQ_READ;
                end
                SEQ_WRITE: begin
                    if (alu_out_valid) begin
                        cnt   <= last_cnt ? '0 : cnt + 1'b1;
                        state <= last_cnt ? SEQ_ACK : SEQ_WRITE;
                    end
                end
                SEQ_MEM: if (lsu_done) state <= SEQ_ACK;
                default: state <= SEQ_IDLE;    // Ack lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && cmd_sel && cmd_req.we) begin
            cmd_q  <= vec_cmd_t'(cmd_req.dat[$bits(vec_cmd_t)-1:0]);
            addr_q <= cmd_req.adr;
        end
    end

endmodule

/* logic/vec_unit_top.sv */
// Vector unit top level: sequencer, register file, ALU and load/store unit
`timescale 1ns/1ps

module vec_unit_top (
    input  logic             clk,
    input  logic             rst,
    input  vec_pkg::wb_req_t cmd_req,
    output vec_pkg::wb_rsp_t cmd_rsp,
    output vec_pkg::wb_req_t mem_req,
    input  vec_pkg::wb_rsp_t mem_rsp
);
    import vec_pkg::*;

    vreg_rd_req_t rd_req_1, rd_req_2, st_req;
    vreg_wr_req_t wr_req, ld_req;
    beat_t        rd_data_1, rd_data_2, st_data, ld_data, alu_result;
    vec_op_e      alu_op;
    logic         alu_valid, alu_out_valid;
    logic         lsu_start, lsu_is_store, lsu_done;
    word_addr_t   lsu_addr;
    vreg_idx_t    lsu_vreg;
    byte_en_t     lsu_mask;

    vec_sequencer i_sequencer (
        .clk, .rst, .cmd_req, .cmd_rsp, .rd_req_1, .rd_req_2, .alu_op, .alu_valid,
        .alu_out_valid, .wr_req, .lsu_start, .lsu_is_store, .lsu_addr, .lsu_vreg,
        .lsu_mask, .lsu_done
    );

    vec_regfile i_regfile (
        .clk, .rst, .rd_req_1, .rd_req_2, .rd_data_1, .rd_data_2, .wr_req,
        .wr_data (alu_result),
        .ld_req, .ld_data, .st_req, .st_data
    );

    vec_alu i_alu (
        .clk, .rst,
        .op        (alu_op),
        .in_valid  (alu_valid),
        .src_a     (rd_data_1),
        .src_b     (rd_data_2),
        .out_valid (alu_out_valid),
        .result    (alu_result)
    );

    vec_lsu i_lsu (
        .clk, .rst,
        .start     (lsu_start),
        .is_store  (lsu_is_store),
        .base_addr (lsu_addr),
        .vreg      (lsu_vreg),
        .mask      (lsu_mask),
        .done      (lsu_done),
        .ld_req, .ld_data, .st_req, .st_data, .mem_req, .mem_rsp
    );

endmodule

/* verification/vec_unit_assertions.sv */
// Protocol assertions for the command and memory Wishbone ports, bound into the vector unit top
`timescale 1ns/1ps

module vec_unit_assertions (
    input logic             clk,
    input logic             rst,
    input vec_pkg::wb_req_t cmd_req,
    input vec_pkg::wb_rsp_t cmd_rsp,
    input vec_pkg::wb_req_t mem_req,
    input vec_pkg::wb_rsp_t mem_rsp
);

    // Memory request held steady until the slave acks
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr)
            && $stable(mem_req.we) && (!mem_req.we || $stable(mem_req.dat)))
        else $error("memory request changed before ack");

    a_cmd_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        cmd_rsp.ack |=> !cmd_rsp.ack)
        else $error("command ack longer than one cycle");

    // Outputs idle right after reset
    a_idle_after_reset: assert property (@(posedge clk)
        rst |=> !mem_req.cyc && !mem_req.stb && !cmd_rsp.ack)
        else $error("bus active after reset");

endmodule

bind vec_unit_top vec_unit_assertions i_assertions (
    .clk, .rst, .cmd_req, .cmd_rsp, .mem_req, .mem_rsp
);

/* verification/vec_unit_tb.sv */
// Vector unit testbench: clock, reset, Wishbone memory model, command table, reference model, watchdog
`timescale 1ns/1ps
`include "vec_config.svh"

module vec_unit_tb;
    import vec_pkg::*;

    localparam int NUM_ROWS  = 18;
    localparam int MEM_WORDS = 64;

    logic    clk;
    logic    rst;
    wb_req_t cmd_req;
    wb_rsp_t cmd_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    beat_t                  mem     [MEM_WORDS];    // Memory model contents
    beat_t                  exp_mem [MEM_WORDS];    // Predicted memory
    logic [`VEC_VLEN-1:0]   shadow  [`VEC_NUM_REGS];

    string      row_name [NUM_ROWS];
    vec_cmd_t   row_cmd  [NUM_ROWS];
    word_addr_t row_addr [NUM_ROWS];

    integer seed = 32'hb1b;
    int     wait_cnt = 0;
    int     errors = 0;
    int     checks = 0;
    int     ack_count = 0;
    logic   started = 1'b0;
    beat_t  rd_value;

    vec_unit_top i_dut (.clk, .rst, .cmd_req, .cmd_rsp, .mem_req, .mem_rsp);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input beat_t expected, input beat_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch in %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int i, input string name, input vec_op_e op, input int vd,
                           input int vs1, input int vs2, input byte_en_t mask, input int addr);
        vec_cmd_t c;
        c.op        = op;
        c.vd        = vreg_idx_t'(vd);
        c.vs1       = vreg_idx_t'(vs1);
        c.vs2       = vreg_idx_t'(vs2);
        c.mask      = mask;
        row_name[i] = name;
        row_cmd[i]  = c;
        row_addr[i] = word_addr_t'(addr);
    endtask

    // Host side of the command port, holds the write until the sequencer acks
    task automatic issue_cmd(input vec_cmd_t c, input word_addr_t a);
        @(negedge clk);
        started     = 1'b1;
        cmd_req.cyc = 1'b1;
        cmd_req.stb = 1'b1;
        cmd_req.we  = 1'b1;
        cmd_req.adr = a;
        cmd_req.dat = beat_t'(c);
        cmd_req.sel = '1;
        @(negedge clk);
        while (!cmd_rsp.ack) @(negedge clk);
        cmd_req = '0;
    endtask

    task automatic read_cmd_port(output beat_t data);
        @(negedge clk);
        started     = 1'b1;
        cmd_req.cyc = 1'b1;
        cmd_req.stb = 1'b1;
        cmd_req.we  = 1'b0;
        @(negedge clk);
        while (!cmd_rsp.ack) @(negedge clk);
        data    = cmd_rsp.dat;
        cmd_req = '0;
    endtask

    // Reference model, elements wrap at 32 bits and the mask repeats on every beat
    task automatic predict(input vec_cmd_t c, input word_addr_t a);
        logic [`VEC_VLEN-1:0] res;
        logic [31:0]          ea;
        logic [31:0]          eb;
        res = '0;
        for (int e = 0; e < `VEC_VLEN / 32; e++) begin
            ea = shadow[c.vs1][32*e +: 32];
            eb = shadow[c.vs2][32*e +: 32];
            case (c.op)
                VADD:    res[32*e +: 32] = ea + eb;
                VSUB:    res[32*e +: 32] = ea - eb;
                VAND:    res[32*e +: 32] = ea & eb;
                VXOR:    res[32*e +: 32] = ea ^ eb;
                default: res[32*e +: 32] = '0;
            endcase
        end
        for (int k = 0; k < BEATS; k++) begin
            if (c.op == VLOAD) begin
                res[64*k +: 64] = exp_mem[(a + k) % MEM_WORDS];
            end else if (c.op == VSTORE) begin
                exp_mem[(a + k) % MEM_WORDS] = shadow[c.vd][64*k +: 64];
            end
        end
        if (c.op != VSTORE) begin
            for (int j = 0; j < `VEC_VLEN / 8; j++) begin
                if (c.mask[j % 8]) shadow[c.vd][8*j +: 8] = res[8*j +: 8];
            end
        end
    endtask

    // Memory slave with a random number of wait states per transfer
    always @(negedge clk) begin
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
            wait_cnt    = $unsigned($random(seed)) % 4;
        end else if (!rst && mem_req.cyc && mem_req.stb) begin
            if (mem_req.adr >= MEM_WORDS) begin
                errors++;
                $display("memory access outside the model at word %0d", mem_req.adr);
            end
            if (wait_cnt == 0) begin
                mem_rsp.ack = 1'b1;
                for (int b = 0; b < 8; b++) begin
                    if (mem_req.we && mem_req.sel[b]) begin
                        mem[mem_req.adr % MEM_WORDS][8*b +: 8] = mem_req.dat[8*b +: 8];
                    end
                end
                if (!mem_req.we) mem_rsp.dat = mem[mem_req.adr % MEM_WORDS];
            end else begin
                wait_cnt--;
            end
        end
    end

    // Ack counter and the quiet check before the first command
    always @(negedge clk) begin
        if (cmd_rsp.ack === 1'b1) ack_count++;
        if (!rst && !started && (mem_req.cyc !== 1'b0 || cmd_rsp.ack !== 1'b0)) begin
            errors++;
            $display("bus activity or command ack seen before the first command");
        end
    end

    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        $display("watchdog expired, the unit stopped responding to commands");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        cmd_req = '0;
        mem_rsp = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = {32'(i * 32'h9e37_79b9), 32'((i + 1) * 32'h85eb_ca6b)};
            exp_mem[i] = mem[i];
        end
        for (int c = 0; c < `VEC_NUM_REGS; c++) shadow[c] = {(`VEC_VLEN / 8){8'(c)}};

        set_row(0,  "init_store_v7",   VSTORE, 7,  0, 0, 8'hff, 40);
        set_row(1,  "load_v1",         VLOAD,  1,  0, 0, 8'hff, 0);
        set_row(2,  "load_v2",         VLOAD,  2,  0, 0, 8'hff, 2);
        set_row(3,  "store_v1",        VSTORE, 1,  0, 0, 8'hff, 42);
        set_row(4,  "vadd_v3",         VADD,   3,  1, 2, 8'hff, 0);
        set_row(5,  "store_v3",        VSTORE, 3,  0, 0, 8'hff, 44);
        set_row(6,  "vsub_v4",         VSUB,   4,  1, 2, 8'hff, 0);
        set_row(7,  "store_v4",        VSTORE, 4,  0, 0, 8'hff, 46);
        set_row(8,  "vand_v5",         VAND,   5,  1, 2, 8'hff, 0);
        set_row(9,  "store_v5",        VSTORE, 5,  0, 0, 8'hff, 48);
        set_row(10, "vxor_v6",         VXOR,   6,  1, 2, 8'hff, 0);
        set_row(11, "store_v6",        VSTORE, 6,  0, 0, 8'hff, 50);
        set_row(12, "load_mask_v9",    VLOAD,  9,  0, 0, 8'h5a, 4);
        set_row(13, "store_v9",        VSTORE, 9,  0, 0, 8'hff, 52);
        set_row(14, "vadd_mask_v10",   VADD,   10, 9, 2, 8'hc3, 0);
        set_row(15, "store_v10",       VSTORE, 10, 0, 0, 8'hff, 54);
        set_row(16, "vxor_inplace_v1", VXOR,   1,  1, 7, 8'hff, 0);
        set_row(17, "store_v1_xor",    VSTORE, 1,  0, 0, 8'hff, 56);

        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);    // Idle window for the reset check

        for (int r = 0; r < NUM_ROWS; r++) begin
            issue_cmd(row_cmd[r], row_addr[r]);
            predict(row_cmd[r], row_addr[r]);
            if (row_cmd[r].op == VSTORE) begin
                for (int k = 0; k < BEATS; k++) begin
                    check_value($sformatf("%s word %0d", row_name[r], k),
                                exp_mem[(row_addr[r] + k) % MEM_WORDS],
                                mem[(row_addr[r] + k) % MEM_WORDS]);
                end
            end
        end

        read_cmd_port(rd_value);
        check_value("cmd_port_read", '0, rd_value);
        repeat (3) @(negedge clk);
        check_value("cmd_ack_count", beat_t'(NUM_ROWS + 1), beat_t'(ack_count));
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("final memory word %0d", i), exp_mem[i], mem[i]);
        end

        $display("%0d checks done, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/vec_pkg.sv
logic/vec_regfile.sv
logic/vec_alu.sv
logic/vec_lsu.sv
logic/vec_sequencer.sv
logic/vec_unit_top.sv
verification/vec_unit_assertions.sv
verification/vec_unit_tb.sv

/* Bender.yml */
package:
  name: vec_unit

export_include_dirs:
  - logic

sources:
  - logic/vec_pkg.sv
  - logic/vec_regfile.sv
  - logic/vec_alu.sv
  - logic/vec_lsu.sv
  - logic/vec_sequencer.sv
  - logic/vec_unit_top.sv
  - target: test
    files:
      - verification/vec_unit_assertions.sv
      - verification/vec_unit_tb.sv
